/* rtl/i3c_rx_consts.svh */
// Line indices must match the top-level pin wiring; filter lengths are in system clock cycles
`ifndef I3C_RX_CONSTS_SVH
`define I3C_RX_CONSTS_SVH

// Filtered bus lines
`define I3C_NUM_LINES 2
`define I3C_SCL_LINE 0
`define I3C_SDA_LINE 1

// Line filter depth
`define I3C_SYNC_STAGES 2
`define I3C_GLITCH_CYCLES 2

// Address and data byte size
`define I3C_BYTE_BITS 8

// RX descriptor flags, byte count sits in bits 15:0
`define I3C_DESC_PERR_BIT 16
`define I3C_DESC_OVF_BIT 17

`endif

/* rtl/i3c_rx_pkg.sv */
// Descriptor layout assumes a 16-bit byte count in the low half of a 32-bit word
`include "i3c_rx_consts.svh"

package i3c_rx_pkg;

  // Address byte carries RnW in bit 0
  typedef logic [`I3C_BYTE_BITS-1:0] i3c_byte_t;
  typedef logic [`I3C_BYTE_BITS-2:0] i3c_addr_t;

  typedef logic [15:0] i3c_byte_cnt_t;
  typedef logic [31:0] i3c_rx_desc_t;

  // Counts up to the ninth bit of a byte
  typedef logic [3:0] i3c_bit_cnt_t;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    WrData,
    Parity,
    Ignore
  } i3c_target_state_e;

endpackage

/* rtl/i3c_rx_ifs.sv */
// No back-pressure on the byte path; every bus event except sda_level is a one-cycle pulse
`timescale 1ns/1ps

interface bus_event_if;
  logic start;
  logic rstart;
  logic stop;
  logic scl_rise;
  logic scl_fall;
  logic sda_level;

  modport monitor(
    output start,
    output rstart,
    output stop,
    output scl_rise,
    output scl_fall,
    output sda_level
  );

  modport target(
    input start,
    input rstart,
    input stop,
    input scl_rise,
    input scl_fall,
    input sda_level
  );
endinterface

interface rx_byte_if;
  import i3c_rx_pkg::*;

  logic      byte_valid;
  i3c_byte_t byte_data;
  logic      parity_err;
  // Only sent for transfers whose address was ACKed
  logic      xfer_end;

  modport source(output byte_valid, output byte_data, output parity_err, output xfer_end);
  modport sink(input byte_valid, input byte_data, input parity_err, input xfer_end);
endinterface

/* rtl/i3c_line_filter.sv */
// Level resets high and lags the pin by the synchronizer depth plus the glitch window
`timescale 1ns/1ps
`include "i3c_rx_consts.svh"

module i3c_line_filter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic line_i,
  output logic level_o,
  output logic rise_o,
  output logic fall_o
);
  localparam int unsigned CntWidth = $clog2(`I3C_GLITCH_CYCLES + 1);

  logic [`I3C_SYNC_STAGES-1:0] sync_q;
  logic                        synced;
  logic [CntWidth-1:0]         stable_cnt_q;
  logic                        accept;
  logic                        level_q;
  logic                        rise_q;
  logic                        fall_q;

  assign synced = sync_q[`I3C_SYNC_STAGES-1];

  // New level held long enough
  assign accept = (synced != level_q) &&
                  (stable_cnt_q == CntWidth'(`I3C_GLITCH_CYCLES - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q       <= '1;
      stable_cnt_q <= '0;
      level_q      <= 1'b1;
      rise_q       <= 1'b0;
      fall_q       <= 1'b0;
    end else begin
      sync_q <= {sync_q[`I3C_SYNC_STAGES-2:0], line_i};
      rise_q <= accept && synced;
      fall_q <= accept && !synced;
      // Any return to the old level restarts the window
      if ((synced == level_q) || accept) begin
        stable_cnt_q <= '0;
      end else begin
        stable_cnt_q <= stable_cnt_q + 1'b1;
      end
      if (accept) begin
        level_q <= synced;
      end
    end
  end

  assign level_o = level_q;
  assign rise_o  = rise_q;
  assign fall_o  = fall_q;

endmodule

/* rtl/i3c_bus_monitor.sv */
// Events lag the filtered edges by one cycle and are suppressed while standby is disabled
`timescale 1ns/1ps
`include "i3c_rx_consts.svh"

module i3c_bus_monitor (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      standby_en_i,
  input  logic [`I3C_NUM_LINES-1:0] line_level_i,
  input  logic [`I3C_NUM_LINES-1:0] line_rise_i,
  input  logic [`I3C_NUM_LINES-1:0] line_fall_i,
  bus_event_if.monitor              evt
);
  logic scl_high;
  logic sda_fall;
  logic sda_rise;
  logic bus_open_q;
  logic start_q;
  logic rstart_q;
  logic stop_q;
  logic scl_rise_q;
  logic scl_fall_q;
  logic sda_level_q;

  assign scl_high = line_level_i[`I3C_SCL_LINE];

  // SDA edges with SCL high are bus conditions
  assign sda_fall = standby_en_i && scl_high && line_fall_i[`I3C_SDA_LINE];
  assign sda_rise = standby_en_i && scl_high && line_rise_i[`I3C_SDA_LINE];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_open_q  <= 1'b0;
      start_q     <= 1'b0;
      rstart_q    <= 1'b0;
      stop_q      <= 1'b0;
      scl_rise_q  <= 1'b0;
      scl_fall_q  <= 1'b0;
      sda_level_q <= 1'b1;
    end else begin
      start_q     <= sda_fall && !bus_open_q;
      rstart_q    <= sda_fall && bus_open_q;
      stop_q      <= sda_rise;
      scl_rise_q  <= standby_en_i && line_rise_i[`I3C_SCL_LINE];
      scl_fall_q  <= standby_en_i && line_fall_i[`I3C_SCL_LINE];
      sda_level_q <= line_level_i[`I3C_SDA_LINE];
      if (!standby_en_i || sda_rise) begin
        bus_open_q <= 1'b0;
      end else if (sda_fall) begin
        bus_open_q <= 1'b1;
      end
    end
  end

  assign evt.start     = start_q;
  assign evt.rstart    = rstart_q;
  assign evt.stop      = stop_q;
  assign evt.scl_rise  = scl_rise_q;
  assign evt.scl_fall  = scl_fall_q;
  assign evt.sda_level = sda_level_q;

endmodule

/* rtl/i3c_target_fsm.sv */
// SDR private writes only; read headers and foreign addresses get no ACK and are ignored
`timescale 1ns/1ps
`include "i3c_rx_consts.svh"

module i3c_target_fsm (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i3c_rx_pkg::i3c_addr_t target_dyn_addr_i,
  input  logic                  target_dyn_addr_valid_i,
  output logic                  sda_o,
  output i3c_rx_pkg::i3c_byte_t addr_o,
  output logic                  addr_valid_o,
  bus_event_if.target           evt,
  rx_byte_if.source             rx
);
  import i3c_rx_pkg::*;

  i3c_target_state_e state_q;
  i3c_bit_cnt_t      bit_cnt_q;
  i3c_byte_t         shift_q;
  i3c_byte_t         next_byte;
  i3c_byte_t         addr_q;
  logic              addr_valid_q;
  logic              addr_match;
  logic              last_bit;
  logic              acked_q;
  logic              sda_q;
  logic              byte_valid_q;
  logic              parity_err_q;
  logic              xfer_end_q;

  assign next_byte = {shift_q[`I3C_BYTE_BITS-2:0], evt.sda_level};
  assign last_bit  = (bit_cnt_q == i3c_bit_cnt_t'(`I3C_BYTE_BITS - 1));

  // Write header to our dynamic address
  assign addr_match = target_dyn_addr_valid_i && !next_byte[0] &&
                      (next_byte[`I3C_BYTE_BITS-1:1] == target_dyn_addr_i);

  always_ff @(posedge clk_i) begin
    if (evt.scl_rise && ((state_q == Addr) || (state_q == WrData))) begin
      shift_q <= next_byte;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      bit_cnt_q    <= '0;
      addr_q       <= '0;
      addr_valid_q <= 1'b0;
      acked_q      <= 1'b0;
      sda_q        <= 1'b1;
      byte_valid_q <= 1'b0;
      parity_err_q <= 1'b0;
      xfer_end_q   <= 1'b0;
    end else begin
      addr_valid_q <= 1'b0;
      byte_valid_q <= 1'b0;
      xfer_end_q   <= 1'b0;
      if (evt.start || evt.rstart || evt.stop) begin
        // Close an ACKed transfer, then restart or go idle
        xfer_end_q <= acked_q;
        acked_q    <= 1'b0;
        sda_q      <= 1'b1;
        bit_cnt_q  <= '0;
        state_q    <= evt.stop ? Idle : Addr;
      end else begin
        unique case (state_q)
          Addr: begin
            if (evt.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (last_bit) begin
                bit_cnt_q    <= '0;
                addr_q       <= next_byte;
                addr_valid_q <= 1'b1;
                state_q      <= addr_match ? AddrAck : Ignore;
              end
            end
          end
          AddrAck: begin
            // Pull SDA low for one full SCL period
            if (evt.scl_fall) begin
              if (sda_q) begin
                sda_q   <= 1'b0;
                acked_q <= 1'b1;
              end else begin
                sda_q   <= 1'b1;
                state_q <= WrData;
              end
            end
          end
          WrData: begin
            if (evt.scl_rise) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (last_bit) begin
                bit_cnt_q <= '0;
                state_q   <= Parity;
              end
            end
          end
          Parity: begin
            if (evt.scl_rise) begin
              byte_valid_q <= 1'b1;
              // T bit must be the inverted XOR of the byte
              parity_err_q <= (evt.sda_level == ^shift_q);
              state_q      <= WrData;
            end
          end
          Idle, Ignore: begin
            sda_q <= 1'b1;
          end
          default: begin
            state_q <= Idle;
          end
        endcase
      end
    end
  end

  assign sda_o        = sda_q;
  assign addr_o       = addr_q;
  assign addr_valid_o = addr_valid_q;

  assign rx.byte_valid = byte_valid_q;
  assign rx.byte_data  = shift_q;
  assign rx.parity_err = parity_err_q;
  assign rx.xfer_end   = xfer_end_q;

endmodule

/* rtl/i3c_rx_descriptor.sv */
// Descriptor queue is assumed never full; bytes seen while the data queue is full are dropped
`timescale 1ns/1ps
`include "i3c_rx_consts.svh"

module i3c_rx_descriptor (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  rx_byte_if.sink                  rx,
  input  logic                     rx_queue_full_i,
  output logic                     rx_queue_wvalid_o,
  output i3c_rx_pkg::i3c_byte_t    rx_queue_wdata_o,
  output logic                     rx_desc_queue_wvalid_o,
  output i3c_rx_pkg::i3c_rx_desc_t rx_desc_queue_wdata_o
);
  import i3c_rx_pkg::*;

  logic          byte_write;
  i3c_byte_cnt_t byte_cnt_q;
  i3c_byte_cnt_t byte_cnt_next;
  logic          perr_q;
  logic          perr_next;
  logic          ovf_q;
  logic          ovf_next;
  i3c_rx_desc_t  desc_next;

  assign byte_write    = rx.byte_valid && !rx_queue_full_i;
  assign byte_cnt_next = byte_cnt_q + i3c_byte_cnt_t'(byte_write);
  assign perr_next     = perr_q || (rx.byte_valid && rx.parity_err);
  assign ovf_next      = ovf_q || (rx.byte_valid && rx_queue_full_i);

  always_comb begin
    desc_next = '0;
    desc_next[$bits(i3c_byte_cnt_t)-1:0] = byte_cnt_next;
    desc_next[`I3C_DESC_PERR_BIT]        = perr_next;
    desc_next[`I3C_DESC_OVF_BIT]         = ovf_next;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      byte_cnt_q             <= '0;
      perr_q                 <= 1'b0;
      ovf_q                  <= 1'b0;
    end else begin
      rx_queue_wvalid_o      <= byte_write;
      rx_desc_queue_wvalid_o <= rx.xfer_end;
      // Start the next transfer with a clean count
      if (rx.xfer_end) begin
        byte_cnt_q <= '0;
        perr_q     <= 1'b0;
        ovf_q      <= 1'b0;
      end else begin
        byte_cnt_q <= byte_cnt_next;
        perr_q     <= perr_next;
        ovf_q      <= ovf_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_write) begin
      rx_queue_wdata_o <= rx.byte_data;
    end
    if (rx.xfer_end) begin
      rx_desc_queue_wdata_o <= desc_next;
    end
  end

endmodule

/* rtl/i3c_target_rx_top.sv */
// SCL is input only and SDA is open-drain, so ctrl_sda_o high means the line is released
`timescale 1ns/1ps
`include "i3c_rx_consts.svh"

module i3c_target_rx_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     ctrl_scl_i,
  input  logic                     ctrl_sda_i,
  output logic                     ctrl_sda_o,
  input  logic                     standby_en_i,
  input  i3c_rx_pkg::i3c_addr_t    target_dyn_addr_i,
  input  logic                     target_dyn_addr_valid_i,
  // RX data queue
  input  logic                     rx_queue_full_i,
  output logic                     rx_queue_wvalid_o,
  output i3c_rx_pkg::i3c_byte_t    rx_queue_wdata_o,
  // RX descriptor queue
  output logic                     rx_desc_queue_wvalid_o,
  output i3c_rx_pkg::i3c_rx_desc_t rx_desc_queue_wdata_o,
  // Bus conditions and received address
  output logic                     bus_start_o,
  output logic                     bus_rstart_o,
  output logic                     bus_stop_o,
  output i3c_rx_pkg::i3c_byte_t    bus_addr_o,
  output logic                     bus_addr_valid_o
);
  logic [`I3C_NUM_LINES-1:0] line_pin;
  logic [`I3C_NUM_LINES-1:0] line_level;
  logic [`I3C_NUM_LINES-1:0] line_rise;
  logic [`I3C_NUM_LINES-1:0] line_fall;

  bus_event_if evt ();
  rx_byte_if   rx ();

  assign line_pin[`I3C_SCL_LINE] = ctrl_scl_i;
  assign line_pin[`I3C_SDA_LINE] = ctrl_sda_i;

  for (genvar i = 0; i < `I3C_NUM_LINES; i++) begin : g_line_filter
    i3c_line_filter xi3c_line_filter (
      .clk_i,
      .rst_ni,
      .line_i (line_pin[i]),
      .level_o(line_level[i]),
      .rise_o (line_rise[i]),
      .fall_o (line_fall[i])
    );
  end

  i3c_bus_monitor xi3c_bus_monitor (
    .clk_i,
    .rst_ni,
    .standby_en_i,
    .line_level_i(line_level),
    .line_rise_i (line_rise),
    .line_fall_i (line_fall),
    .evt         (evt.monitor)
  );

  i3c_target_fsm xi3c_target_fsm (
    .clk_i,
    .rst_ni,
    .target_dyn_addr_i,
    .target_dyn_addr_valid_i,
    .sda_o       (ctrl_sda_o),
    .addr_o      (bus_addr_o),
    .addr_valid_o(bus_addr_valid_o),
    .evt         (evt.target),
    .rx          (rx.source)
  );

  i3c_rx_descriptor xi3c_rx_descriptor (
    .clk_i,
    .rst_ni,
    .rx(rx.sink),
    .rx_queue_full_i,
    .rx_queue_wvalid_o,
    .rx_queue_wdata_o,
    .rx_desc_queue_wvalid_o,
    .rx_desc_queue_wdata_o
  );

  assign bus_start_o  = evt.start;
  assign bus_rstart_o = evt.rstart;
  assign bus_stop_o   = evt.stop;

endmodule

/* verif/tb_clock_gen.sv */
// Free-running 40 ns clock; reset is released 1 ns after the fourth rising edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);
  localparam time HalfPeriod  = 20ns;
  localparam int  ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

/* verif/tb_i3c_target_rx.sv */
// SCL runs at 20 system clocks per bit; only SDR private writes are modelled on the bus
`timescale 1ns/1ps
`include "i3c_rx_consts.svh"

module tb_i3c_target_rx;
  import i3c_rx_pkg::*;

  localparam int        SclHalf     = 10;
  localparam int        DescTimeout = 200;
  localparam i3c_addr_t DynAddr     = 7'h2a;

  logic         clk;
  logic         rst_n;
  logic         scl;
  logic         ctl_sda;
  logic         bus_sda;
  logic         sda_out;
  logic         standby_en;
  i3c_addr_t    dyn_addr;
  logic         dyn_addr_valid;
  logic         rx_full;
  logic         rx_wvalid;
  i3c_byte_t    rx_wdata;
  logic         desc_wvalid;
  i3c_rx_desc_t desc_wdata;
  logic         bus_start;
  logic         bus_rstart;
  logic         bus_stop;
  i3c_byte_t    bus_addr;
  logic         bus_addr_valid;

  int           err_cnt = 0;
  int           check_cnt = 0;
  int           test_cnt = 0;
  int           start_cnt;
  int           rstart_cnt;
  int           stop_cnt;
  int           addr_cnt;
  i3c_byte_t    last_addr;
  i3c_byte_t    sent_q[$];
  logic         bad_t_q[$];
  logic         full_q[$];
  i3c_byte_t    got_bytes[$];
  i3c_rx_desc_t got_descs[$];

  tb_clock_gen clock_gen (.clk_o(clk), .rst_no(rst_n));

  // Open-drain bus where either side can pull low
  assign bus_sda = ctl_sda & sda_out;

  i3c_target_rx_top dut (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .ctrl_scl_i             (scl),
    .ctrl_sda_i             (bus_sda),
    .ctrl_sda_o             (sda_out),
    .standby_en_i           (standby_en),
    .target_dyn_addr_i      (dyn_addr),
    .target_dyn_addr_valid_i(dyn_addr_valid),
    .rx_queue_full_i        (rx_full),
    .rx_queue_wvalid_o      (rx_wvalid),
    .rx_queue_wdata_o       (rx_wdata),
    .rx_desc_queue_wvalid_o (desc_wvalid),
    .rx_desc_queue_wdata_o  (desc_wdata),
    .bus_start_o            (bus_start),
    .bus_rstart_o           (bus_rstart),
    .bus_stop_o             (bus_stop),
    .bus_addr_o             (bus_addr),
    .bus_addr_valid_o       (bus_addr_valid)
  );

  // Queue model and bus-condition counters
  always @(negedge clk) begin
    if (rx_wvalid) got_bytes.push_back(rx_wdata);
    if (desc_wvalid) got_descs.push_back(desc_wdata);
    if (bus_start) start_cnt++;
    if (bus_rstart) rstart_cnt++;
    if (bus_stop) stop_cnt++;
    if (bus_addr_valid) begin
      addr_cnt++;
      last_addr = bus_addr;
    end
  end

  // Odd parity T bit is the inverted XOR of the byte
  function automatic logic t_bit_of(input i3c_byte_t b, input logic corrupt);
    return (~^b) ^ corrupt;
  endfunction

  function automatic i3c_rx_desc_t expect_desc(input int first, input int n);
    i3c_byte_cnt_t cnt;
    logic          perr;
    logic          ovf;
    i3c_rx_desc_t  d;
    cnt  = '0;
    perr = 1'b0;
    ovf  = 1'b0;
    for (int i = first; i < first + n; i++) begin
      if (full_q[i]) ovf = 1'b1;
      else cnt = cnt + 1'b1;
      if (bad_t_q[i]) perr = 1'b1;
    end
    d = '0;
    d[15:0] = cnt;
    d[`I3C_DESC_PERR_BIT] = perr;
    d[`I3C_DESC_OVF_BIT]  = ovf;
    return d;
  endfunction

  task automatic check_byte(input string what, input i3c_byte_t got, input i3c_byte_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_desc(input string what, input i3c_rx_desc_t got, input i3c_rx_desc_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_events(input int starts, input int rstarts, input int stops);
    check_count("START pulses", start_cnt, starts);
    check_count("Repeated START pulses", rstart_cnt, rstarts);
    check_count("STOP pulses", stop_cnt, stops);
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_reset();
    int cycles = 0;
    while (!rst_n && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n) begin
      err_cnt++;
      $display("Reset was never released");
    end
  endtask

  task automatic wait_descs(input int count);
    int cycles = 0;
    while (got_descs.size() < count && cycles < DescTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (got_descs.size() < count) begin
      err_cnt++;
      $display("Timed out after %0d cycles waiting for descriptor %0d", cycles, count);
    end
  endtask

  task automatic clear_model();
    sent_q.delete();
    bad_t_q.delete();
    full_q.delete();
    got_bytes.delete();
    got_descs.delete();
    start_cnt  = 0;
    rstart_cnt = 0;
    stop_cnt   = 0;
    addr_cnt   = 0;
  endtask

  task automatic prepare_data(input int n, input int bad_idx, input logic [15:0] full_mask);
    i3c_byte_t b;
    for (int i = 0; i < n; i++) begin
      b = $urandom % 256;
      sent_q.push_back(b);
      bad_t_q.push_back(i == bad_idx);
      full_q.push_back(full_mask[i]);
    end
  endtask

  // SCL low on entry and on return; SDA changes mid-low
  task automatic send_bit(input logic b, output logic seen);
    tick(SclHalf / 2);
    ctl_sda = b;
    tick(SclHalf / 2);
    scl = 1'b1;
    tick(SclHalf / 2);
    seen = bus_sda;
    tick(SclHalf / 2);
    scl = 1'b0;
  endtask

  task automatic start_cond();
    tick(SclHalf);
    ctl_sda = 1'b0;
    tick(SclHalf);
    scl = 1'b0;
  endtask

  task automatic rstart_cond();
    tick(SclHalf / 2);
    ctl_sda = 1'b1;
    tick(SclHalf / 2);
    scl = 1'b1;
    tick(SclHalf);
    ctl_sda = 1'b0;
    tick(SclHalf);
    scl = 1'b0;
  endtask

  task automatic stop_cond();
    tick(SclHalf / 2);
    ctl_sda = 1'b0;
    tick(SclHalf / 2);
    scl = 1'b1;
    tick(SclHalf);
    ctl_sda = 1'b1;
    tick(2 * SclHalf);
  endtask

  task automatic send_frame(input i3c_byte_t hdr, input int first, input int n,
                            output logic ack);
    logic      seen;
    i3c_byte_t b;
    for (int i = `I3C_BYTE_BITS - 1; i >= 0; i--) send_bit(hdr[i], seen);
    send_bit(1'b1, ack);
    for (int j = first; j < first + n; j++) begin
      b = sent_q[j];
      rx_full = full_q[j];
      for (int i = `I3C_BYTE_BITS - 1; i >= 0; i--) send_bit(b[i], seen);
      send_bit(t_bit_of(b, bad_t_q[j]), seen);
    end
    rx_full = 1'b0;
  endtask

  // Bytes seen while the queue was full must be missing
  task automatic compare_bytes();
    int k;
    k = 0;
    for (int i = 0; i < sent_q.size(); i++) begin
      if (!full_q[i]) begin
        if (k < got_bytes.size()) check_byte("RX queue byte", got_bytes[k], sent_q[i]);
        k++;
      end
    end
    check_count("RX queue writes", got_bytes.size(), k);
  endtask

  task automatic check_desc_at(input int idx, input i3c_rx_desc_t exp);
    if (idx < got_descs.size()) check_desc("RX descriptor", got_descs[idx], exp);
  endtask

  task automatic run_write(input int n, input int bad_idx, input logic [15:0] full_mask);
    logic ack;
    clear_model();
    prepare_data(n, bad_idx, full_mask);
    start_cond();
    send_frame({DynAddr, 1'b0}, 0, n, ack);
    stop_cond();
    wait_descs(1);
    check_bit("ACK level", ack, 1'b0);
    compare_bytes();
    check_count("Descriptors", got_descs.size(), 1);
    check_desc_at(0, expect_desc(0, n));
    check_events(1, 0, 1);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("Test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "passed" : "failed");
  endtask

  initial begin : main
    logic      ack;
    int        errs;
    int        n1;
    int        n2;
    i3c_byte_t hdr;
    void'($urandom(28384));
    scl            = 1'b1;
    ctl_sda        = 1'b1;
    standby_en     = 1'b1;
    dyn_addr       = DynAddr;
    dyn_addr_valid = 1'b1;
    rx_full        = 1'b0;
    wait_reset();
    tick(1);
    check_bit("SDA after reset", sda_out, 1'b1);
    tick(SclHalf);
    check_events(0, 0, 0);
    check_count("Address strobes", addr_cnt, 0);
    check_count("Writes after reset", got_bytes.size() + got_descs.size(), 0);

    errs = err_cnt;
    run_write(1 + $urandom % 6, -1, '0);
    report_test("addressed write", errs);

    errs = err_cnt;
    for (int k = 0; k < 2; k++) begin
      clear_model();
      prepare_data(1, -1, '0);
      hdr = (k == 0) ? {DynAddr ^ 7'h11, 1'b0} : {DynAddr, 1'b1};
      start_cond();
      send_frame(hdr, 0, 1, ack);
      stop_cond();
      check_bit("ACK level", ack, 1'b1);
      check_count("RX queue writes", got_bytes.size(), 0);
      check_count("Descriptors", got_descs.size(), 0);
      check_byte("Bus address", last_addr, hdr);
    end
    report_test("foreign and read headers", errs);

    errs = err_cnt;
    n1 = 2 + $urandom % 5;
    run_write(n1, $urandom % n1, '0);
    report_test("parity error", errs);

    errs = err_cnt;
    run_write(6, -1, 16'b01_0010);
    report_test("queue overflow", errs);

    errs = err_cnt;
    clear_model();
    n1 = 1 + $urandom % 4;
    n2 = 1 + $urandom % 4;
    prepare_data(n1, -1, '0);
    prepare_data(n2, -1, '0);
    start_cond();
    send_frame({DynAddr, 1'b0}, 0, n1, ack);
    rstart_cond();
    send_frame({DynAddr, 1'b0}, n1, n2, ack);
    stop_cond();
    wait_descs(2);
    compare_bytes();
    check_count("Descriptors", got_descs.size(), 2);
    check_desc_at(0, expect_desc(0, n1));
    check_desc_at(1, expect_desc(n1, n2));
    check_events(1, 1, 1);
    report_test("repeated START", errs);

    errs = err_cnt;
    standby_en = 1'b0;
    clear_model();
    prepare_data(2, -1, '0);
    start_cond();
    send_frame({DynAddr, 1'b0}, 0, 2, ack);
    stop_cond();
    check_bit("ACK level", ack, 1'b1);
    check_events(0, 0, 0);
    check_count("Address strobes", addr_cnt, 0);
    check_count("RX queue writes", got_bytes.size(), 0);
    check_count("Descriptors", got_descs.size(), 0);
    standby_en = 1'b1;
    report_test("disabled target", errs);

    $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/i3c_rx_pkg.sv
rtl/i3c_rx_ifs.sv
rtl/i3c_line_filter.sv
rtl/i3c_bus_monitor.sv
rtl/i3c_target_fsm.sv
rtl/i3c_rx_descriptor.sv
rtl/i3c_target_rx_top.sv
verif/tb_clock_gen.sv
verif/tb_i3c_target_rx.sv
